/* tests/rvv_lite_tests.txt */
# name op src_a src_b expected, all values hex words with element 3 first
# each command is tagged with its line number in this file
add_basic add 01020304 10203040 11223344
add_wrap add ff80017f 0180ff81 00000000
add_no_carry add 12fe34fd 00050006 12033403
sub_basic sub 50403020 10101010 40302010
sub_wrap sub 00010280 01020381 ffffffff
sub_no_borrow sub 10001000 01010101 0fff0fff
mul_basic mul 02030405 03040506 060c141e
mul_low_byte mul ff10807f ff10027f 01000001
add_after_mul_a add 01010101 01010101 02020202
add_after_mul_b add a0b0c0d0 0a0b0c0d aabbccdd
mul_mixed mul 11223344 0f0e0d0c ffdc9730
sub_after_mul sub 00000000 01020304 fffefdfc
mul_zero mul deadbeef 00000000 00000000
mul_one mul deadbeef 01010101 deadbeef
add_ident add cafef00d 00000000 cafef00d
mul_square mul 81c3e7ff 81c3e7ff 01897101
sub_self sub 5a5a5a5a 5a5a5a5a 00000000
add_tail add 7f7f7f7f 01010101 80808080

/* rvv_lite.f */
logic/rvv_lite_pkg.sv
logic/rvv_cmd_queue.sv
logic/rvv_dispatch.sv
logic/rvv_alu.sv
logic/rvv_mul.sv
logic/rvv_rob.sv
logic/rvv_lite_top.sv
tests/rvv_lite_checker.sv
tests/rvv_lite_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rvv_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rvv_lite_tb -f rvv_lite.f -o rvv_lite_sim \
    && ./obj_dir/rvv_lite_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "STATUS: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tests/rvv_lite_tb.sv */
`timescale 1ns/1ns

module rvv_lite_tb;

    localparam int    period         = 100;
    localparam int    reset_cycles   = 8;
    localparam int    timeout_factor = 20;
    localparam int    timeout_base   = 100;
    localparam int    max_tests      = 64;
    localparam string test_file      = "tests/rvv_lite_tests.txt";

    logic                                               clk = 1'b0;
    logic                                               rst_n = 1'b0;
    logic               [rvv_lite_pkg::issue_lanes-1:0] cmd_valid;
    rvv_lite_pkg::cmd_t [rvv_lite_pkg::issue_lanes-1:0] cmd;
    logic               [rvv_lite_pkg::issue_lanes-1:0] cmd_ready;
    logic                                               rt_valid;
    rvv_lite_pkg::retire_t                              rt;
    logic                                               rt_ready;

    // Test table from the data file
    string                          test_name [max_tests];
    rvv_lite_pkg::op_e              test_op   [max_tests];
    logic [rvv_lite_pkg::vlen-1:0]  test_a    [max_tests];
    logic [rvv_lite_pkg::vlen-1:0]  test_b    [max_tests];
    logic [rvv_lite_pkg::tag_w-1:0] test_tag  [max_tests];
    int                             n_tests = 0;
    logic                           load_ok = 1'b0;

    int     next_test     = 0;
    logic   stall_done    = 1'b0;
    integer seed          = 32'hfd0d;
    int     rnd;
    int     cycle_count   = 0;
    int     timeout_limit = 0;

    int   retired_count;
    int   error_count;
    logic all_retired;

    rvv_lite_top rvv_lite_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rt_valid  (rt_valid),
        .rt        (rt),
        .rt_ready  (rt_ready)
    );

    rvv_lite_checker result_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_ready     (cmd_ready),
        .rt_valid      (rt_valid),
        .rt            (rt),
        .rt_ready      (rt_ready),
        .retired_count (retired_count),
        .error_count   (error_count),
        .all_retired   (all_retired)
    );

    always #(period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic parse_op(input string text, output rvv_lite_pkg::op_e op);
        parse_op = 1'b1;
        op = rvv_lite_pkg::op_add;
        if (text == "sub") begin
            op = rvv_lite_pkg::op_sub;
        end else if (text == "mul") begin
            op = rvv_lite_pkg::op_mul;
        end else if (text != "add") begin
            parse_op = 1'b0;
        end
    endfunction

    function automatic rvv_lite_pkg::cmd_t make_cmd(input int i);
        return '{tag: test_tag[i], op: test_op[i], src_a: test_a[i], src_b: test_b[i]};
    endfunction

    task automatic load_tests();
        int                fd;
        int                line_no;
        int                code;
        string             line;
        string             name;
        string             op_text;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       expected;
        rvv_lite_pkg::op_e op;
        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            $display("Cannot open test file %s", test_file);
            return;
        end
        line_no = 0;
        load_ok = 1'b1;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            code = $sscanf(line, "%s %s %h %h %h", name, op_text, a, b, expected);
            if (line.getc(0) == "#" || code != 5) begin
                continue;
            end
            if (!parse_op(op_text, op) || n_tests >= max_tests) begin
                $display("Bad test on line %0d of %s", line_no, test_file);
                load_ok = 1'b0;
                continue;
            end
            test_name[n_tests] = name;
            test_op[n_tests]   = op;
            test_a[n_tests]    = a;
            test_b[n_tests]    = b;
            // Line number doubles as the issuer tag
            test_tag[n_tests]  = line_no[7:0];
            result_checker.add_expected(name, line_no[7:0], expected);
            n_tests++;
        end
        $fclose(fd);
        if (n_tests == 0) begin
            $display("No tests found in %s", test_file);
            load_ok = 1'b0;
        end
    endtask

    // Two lanes when lane 1 is ready, else one
    task automatic drive_commands();
        cmd_valid = '0;
        if (next_test < n_tests) begin
            if (cmd_ready[1] && next_test + 1 < n_tests) begin
                cmd[0]    = make_cmd(next_test);
                cmd[1]    = make_cmd(next_test + 1);
                cmd_valid = 2'b11;
                next_test = next_test + 2;
            end else if (cmd_ready[0]) begin
                cmd[0]    = make_cmd(next_test);
                cmd_valid = 2'b01;
                next_test = next_test + 1;
            end else if (next_test > 0) begin
                // Queue full behind a stalled ROB
                stall_done = 1'b1;
            end
        end else begin
            stall_done = 1'b1;
        end
    endtask

    task automatic drive_retire_ready();
        if (!stall_done) begin
            rt_ready = 1'b0;
        end else begin
            rnd = $random(seed);
            // Ready about three cycles in four
            rt_ready = (rnd[1:0] != 2'b00);
        end
    endtask

    task automatic wait_for_results();
        while (!all_retired && cycle_count < timeout_limit) begin
            @(posedge clk);
        end
        if (all_retired) begin
            // Idle cycles to catch a duplicate retire
            repeat (4) @(posedge clk);
        end else begin
            $display("Timeout after %0d cycles: %0d of %0d results retired",
                     cycle_count, retired_count, n_tests);
        end
        // Checker counts from the last rising edge settle here
        @(negedge clk);
    endtask

    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            drive_commands();
            drive_retire_ready();
        end
    end

    initial begin
        cmd_valid = '0;
        cmd       = '0;
        rt_ready  = 1'b0;
        rst_n     = 1'b0;
        load_tests();
        timeout_limit = timeout_factor * n_tests + timeout_base;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (load_ok) begin
            wait_for_results();
        end
        result_checker.report_counts();
        if (load_ok && all_retired && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tests/rvv_lite_checker.sv */
`timescale 1ns/1ns

module rvv_lite_checker (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [rvv_lite_pkg::issue_lanes-1:0] cmd_ready,
    input  logic                                 rt_valid,
    input  rvv_lite_pkg::retire_t                rt,
    input  logic                                 rt_ready,
    output int                                   retired_count,
    output int                                   error_count,
    output logic                                 all_retired
);

    localparam int max_tests = 64;

    // Expected results in command order
    string                          exp_name [max_tests];
    logic [rvv_lite_pkg::tag_w-1:0] exp_tag  [max_tests];
    logic [rvv_lite_pkg::vlen-1:0]  exp_data [max_tests];
    int                             n_expected = 0;

    int   retired       = 0;
    int   n_correct     = 0;
    int   errors        = 0;
    logic ready_armed   = 1'b0;
    logic lane1_dropped = 1'b0;
    logic lane0_dropped = 1'b0;

    assign retired_count = retired;
    assign error_count   = errors;
    assign all_retired   = (n_expected > 0) && (retired == n_expected);

    task automatic add_expected(input string name, input logic [7:0] tag,
                                input logic [31:0] data);
        if (n_expected < max_tests) begin
            exp_name[n_expected] = name;
            exp_tag[n_expected]  = tag;
            exp_data[n_expected] = data;
            n_expected = n_expected + 1;
        end
    endtask

    task automatic report_counts();
        $display("Summary: %0d tests, %0d retired, %0d correct, %0d errors",
                 n_expected, retired, n_correct, errors);
    endtask

    always @(posedge clk) begin
        int new_errors;
        int new_correct;
        new_errors  = 0;
        new_correct = 0;
        if (rst_n) begin
            // One expected entry per retire transfer
            if (rt_valid && rt_ready) begin
                if (retired >= n_expected) begin
                    $display("Unexpected result with tag %0d after all tests retired", rt.tag);
                    new_errors++;
                end else if (rt.tag !== exp_tag[retired]) begin
                    $display("Result out of order at %s: expected tag %0d, got tag %0d",
                             exp_name[retired], exp_tag[retired], rt.tag);
                    new_errors++;
                end else if (rt.data !== exp_data[retired]) begin
                    $display("Mismatch %s: expected %h, actual %h",
                             exp_name[retired], exp_data[retired], rt.data);
                    new_errors++;
                end else begin
                    $display("ok %s: tag %0d data %h", exp_name[retired], rt.tag, rt.data);
                    new_correct++;
                end
                if (retired + 1 == n_expected && !lane0_dropped) begin
                    $display("Command queue never filled, lane ready order was not seen");
                    new_errors++;
                end
                retired <= retired + 1;
            end

            // Lane ready order once both lanes have been up
            if (!ready_armed) begin
                if (cmd_ready[0] && cmd_ready[1]) begin
                    ready_armed <= 1'b1;
                end
            end else begin
                if (cmd_ready[1] && !cmd_ready[0]) begin
                    $display("Lane 1 of the command queue is ready while lane 0 is not");
                    new_errors++;
                end
                if (!cmd_ready[1]) begin
                    lane1_dropped <= 1'b1;
                end
                if (!cmd_ready[0] && !lane0_dropped) begin
                    lane0_dropped <= 1'b1;
                    if (!lane1_dropped) begin
                        $display("Lane 0 ready dropped without lane 1 dropping first");
                        new_errors++;
                    end
                end
            end
        end
        errors    <= errors + new_errors;
        n_correct <= n_correct + new_correct;
    end

endmodule

/* logic/rvv_lite_top.sv */
`timescale 1ns/1ns

module rvv_lite_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic               [rvv_lite_pkg::issue_lanes-1:0] cmd_valid,
    input  rvv_lite_pkg::cmd_t [rvv_lite_pkg::issue_lanes-1:0] cmd,
    output logic               [rvv_lite_pkg::issue_lanes-1:0] cmd_ready,
    output logic                                              rt_valid,
    output rvv_lite_pkg::retire_t                             rt,
    input  logic                                              rt_ready
);

    // Queue to dispatch
    logic               q_valid;
    rvv_lite_pkg::cmd_t q_cmd;
    logic               q_pop;

    // Dispatch to ROB
    logic                               alloc;
    logic                               alloc_ready;
    logic [rvv_lite_pkg::rob_idx_w-1:0] alloc_idx;
    logic [rvv_lite_pkg::tag_w-1:0]     alloc_tag;

    // Dispatch to units
    logic                 alu_valid;
    logic                 mul_valid;
    rvv_lite_pkg::issue_t alu_uop;
    rvv_lite_pkg::issue_t mul_uop;

    // Units to ROB
    logic              alu_wb_valid;
    logic              mul_wb_valid;
    rvv_lite_pkg::wb_t alu_wb;
    rvv_lite_pkg::wb_t mul_wb;

    rvv_cmd_queue u_cmd_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .q_pop     (q_pop),
        .q_valid   (q_valid),
        .q_cmd     (q_cmd)
    );

    rvv_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .q_valid     (q_valid),
        .q_cmd       (q_cmd),
        .q_pop       (q_pop),
        .alloc_ready (alloc_ready),
        .alloc_idx   (alloc_idx),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .alu_valid   (alu_valid),
        .mul_valid   (mul_valid),
        .alu_uop     (alu_uop),
        .mul_uop     (mul_uop)
    );

    rvv_alu u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_valid    (alu_valid),
        .alu_uop      (alu_uop),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb       (alu_wb)
    );

    rvv_mul u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .mul_valid    (mul_valid),
        .mul_uop      (mul_uop),
        .mul_wb_valid (mul_wb_valid),
        .mul_wb       (mul_wb)
    );

    rvv_rob u_rob (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .alloc_ready  (alloc_ready),
        .alloc_idx    (alloc_idx),
        .alu_wb_valid (alu_wb_valid),
        .mul_wb_valid (mul_wb_valid),
        .alu_wb       (alu_wb),
        .mul_wb       (mul_wb),
        .rt_valid     (rt_valid),
        .rt           (rt),
        .rt_ready     (rt_ready)
    );

endmodule

/* logic/rvv_rob.sv */
`timescale 1ns/1ns

module rvv_rob (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               alloc,
    input  logic [rvv_lite_pkg::tag_w-1:0]     alloc_tag,
    output logic                               alloc_ready,
    output logic [rvv_lite_pkg::rob_idx_w-1:0] alloc_idx,
    input  logic                               alu_wb_valid,
    input  logic                               mul_wb_valid,
    input  rvv_lite_pkg::wb_t                  alu_wb,
    input  rvv_lite_pkg::wb_t                  mul_wb,
    output logic                               rt_valid,
    output rvv_lite_pkg::retire_t              rt,
    input  logic                               rt_ready
);

    typedef logic [$clog2(rvv_lite_pkg::rob_depth+1)-1:0] cnt_t;

    // Entry state
    logic [rvv_lite_pkg::rob_depth-1:0] busy;
    logic [rvv_lite_pkg::rob_depth-1:0] done;
    logic [rvv_lite_pkg::tag_w-1:0]     tag_mem  [rvv_lite_pkg::rob_depth];
    logic [rvv_lite_pkg::vlen-1:0]      data_mem [rvv_lite_pkg::rob_depth];

    logic [rvv_lite_pkg::rob_idx_w-1:0] head;
    logic [rvv_lite_pkg::rob_idx_w-1:0] tail;
    cnt_t                               count;
    logic                               retire;

    assign alloc_ready = (count != cnt_t'(rvv_lite_pkg::rob_depth));
    assign alloc_idx   = tail;

    // Head is offered once its result has been written back
    assign rt_valid = busy[head] & done[head];
    assign rt       = '{tag: tag_mem[head], data: data_mem[head]};
    assign retire   = rt_valid & rt_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            // Both units may complete in one cycle on different entries
            if (alu_wb_valid) begin
                done[alu_wb.rob_idx] <= 1'b1;
            end
            if (mul_wb_valid) begin
                done[mul_wb.rob_idx] <= 1'b1;
            end
            if (retire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + cnt_t'(alloc) - cnt_t'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[tail] <= alloc_tag;
        end
        if (alu_wb_valid) begin
            data_mem[alu_wb.rob_idx] <= alu_wb.data;
        end
        if (mul_wb_valid) begin
            data_mem[mul_wb.rob_idx] <= mul_wb.data;
        end
    end

    // Write-backs must hit an entry allocated earlier and still waiting
    rob_wb_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        (alu_wb_valid |-> busy[alu_wb.rob_idx] && !done[alu_wb.rob_idx]) and
        (mul_wb_valid |-> busy[mul_wb.rob_idx] && !done[mul_wb.rob_idx])
    ) else $error("Write-back to a ROB entry that is not pending");

    rob_rt_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rt_valid && !rt_ready |=> rt_valid && $stable(rt)
    ) else $error("Retire payload changed while stalled");

endmodule

/* logic/rvv_mul.sv */
`timescale 1ns/1ns

module rvv_mul (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mul_valid,
    input  rvv_lite_pkg::issue_t mul_uop,
    output logic                 mul_wb_valid,
    output rvv_lite_pkg::wb_t    mul_wb
);

    // One valid bit per stage
    logic [rvv_lite_pkg::mul_stages-1:0] vld;

    logic [rvv_lite_pkg::num_elem-1:0][2*rvv_lite_pkg::sew-1:0] prod_s1;
    logic [rvv_lite_pkg::rob_idx_w-1:0]                         idx_s1;
    logic [rvv_lite_pkg::vlen-1:0]                              low_s2;
    logic [rvv_lite_pkg::rob_idx_w-1:0]                         idx_s2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[rvv_lite_pkg::mul_stages-2:0], mul_valid};
        end
    end

    assign mul_wb_valid = vld[rvv_lite_pkg::mul_stages-1];

    always_ff @(posedge clk) begin
        // Stage 1 full-width element products
        if (mul_valid) begin
            for (int e = 0; e < rvv_lite_pkg::num_elem; e++) begin
                prod_s1[e] <= mul_uop.src_a[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] *
                              mul_uop.src_b[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew];
            end
            idx_s1 <= mul_uop.rob_idx;
        end

        // Stage 2 keeps the low byte of each product
        if (vld[0]) begin
            for (int e = 0; e < rvv_lite_pkg::num_elem; e++) begin
                low_s2[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] <=
                    prod_s1[e][rvv_lite_pkg::sew-1:0];
            end
            idx_s2 <= idx_s1;
        end

        // Stage 3 write-back register
        if (vld[1]) begin
            mul_wb <= '{rob_idx: idx_s2, data: low_s2};
        end
    end

endmodule

/* logic/rvv_alu.sv */
`timescale 1ns/1ns

module rvv_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alu_valid,
    input  rvv_lite_pkg::issue_t alu_uop,
    output logic                 alu_wb_valid,
    output rvv_lite_pkg::wb_t    alu_wb
);

    logic [rvv_lite_pkg::vlen-1:0] result;

    // Per-element add or subtract with no carry across elements
    always_comb begin
        for (int e = 0; e < rvv_lite_pkg::num_elem; e++) begin
            if (alu_uop.op == rvv_lite_pkg::op_sub) begin
                result[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] =
                    alu_uop.src_a[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] -
                    alu_uop.src_b[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew];
            end else begin
                result[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] =
                    alu_uop.src_a[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] +
                    alu_uop.src_b[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_wb_valid <= 1'b0;
        end else begin
            alu_wb_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            alu_wb <= '{rob_idx: alu_uop.rob_idx, data: result};
        end
    end

endmodule

/* logic/rvv_dispatch.sv */
`timescale 1ns/1ns

module rvv_dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   q_valid,
    input  rvv_lite_pkg::cmd_t                     q_cmd,
    output logic                                   q_pop,
    input  logic                                   alloc_ready,
    input  logic [rvv_lite_pkg::rob_idx_w-1:0]     alloc_idx,
    output logic                                   alloc,
    output logic [rvv_lite_pkg::tag_w-1:0]         alloc_tag,
    output logic                                   alu_valid,
    output logic                                   mul_valid,
    output rvv_lite_pkg::issue_t                   alu_uop,
    output rvv_lite_pkg::issue_t                   mul_uop
);

    rvv_lite_pkg::issue_t uop;
    logic                 is_mul;

    // Pop and take a ROB slot on the same edge
    assign q_pop     = q_valid & alloc_ready;
    assign alloc     = q_pop;
    assign alloc_tag = q_cmd.tag;

    assign is_mul = (q_cmd.op == rvv_lite_pkg::op_mul);

    assign uop = '{rob_idx: alloc_idx, op: q_cmd.op, src_a: q_cmd.src_a, src_b: q_cmd.src_b};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
            mul_valid <= 1'b0;
        end else begin
            alu_valid <= q_pop & ~is_mul;
            mul_valid <= q_pop & is_mul;
        end
    end

    // Operand registers only load for the unit that gets the uop
    always_ff @(posedge clk) begin
        if (q_pop && !is_mul) begin
            alu_uop <= uop;
        end
        if (q_pop && is_mul) begin
            mul_uop <= uop;
        end
    end

    dp_one_unit: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(alu_valid && mul_valid)
    ) else $error("Dispatch issued to ALU and MUL in the same cycle");

endmodule

/* logic/rvv_cmd_queue.sv */
`timescale 1ns/1ns

module rvv_cmd_queue (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic               [rvv_lite_pkg::issue_lanes-1:0] cmd_valid,
    input  rvv_lite_pkg::cmd_t [rvv_lite_pkg::issue_lanes-1:0] cmd,
    output logic               [rvv_lite_pkg::issue_lanes-1:0] cmd_ready,
    input  logic                                              q_pop,
    output logic                                              q_valid,
    output rvv_lite_pkg::cmd_t                                q_cmd
);

    typedef logic [$clog2(rvv_lite_pkg::cq_depth)-1:0]   ptr_t;
    typedef logic [$clog2(rvv_lite_pkg::cq_depth+1)-1:0] cnt_t;

    rvv_lite_pkg::cmd_t mem [rvv_lite_pkg::cq_depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    cnt_t n_push;
    cnt_t next_count;

    logic [rvv_lite_pkg::issue_lanes-1:0] acc;
    logic [rvv_lite_pkg::issue_lanes-1:0] next_ready;

    // Lanes taken this cycle
    assign acc = cmd_valid & cmd_ready;

    always_comb begin
        n_push = '0;
        for (int i = 0; i < rvv_lite_pkg::issue_lanes; i++) begin
            n_push = n_push + cnt_t'(acc[i]);
        end
        next_count = count + n_push - cnt_t'(q_pop);

        // Lane i needs i+1 free slots
        for (int i = 0; i < rvv_lite_pkg::issue_lanes; i++) begin
            next_ready[i] = (next_count <= cnt_t'(rvv_lite_pkg::cq_depth - 1 - i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            cmd_ready <= '0;
        end else begin
            wr_ptr    <= wr_ptr + ptr_t'(n_push);
            rd_ptr    <= rd_ptr + ptr_t'(q_pop);
            count     <= next_count;
            cmd_ready <= next_ready;
        end
    end

    // Accepted lanes land in consecutive slots from the write pointer
    always_ff @(posedge clk) begin
        for (int i = 0; i < rvv_lite_pkg::issue_lanes; i++) begin
            if (acc[i]) begin
                mem[wr_ptr + ptr_t'(i)] <= cmd[i];
            end
        end
    end

    assign q_valid = (count != '0);
    assign q_cmd   = mem[rd_ptr];

    // Lane 1 only together with lane 0, so accepted lanes are all ones from bit 0
    cq_push_prefix: assert property (
        @(posedge clk) disable iff (!rst_n)
        (acc & (acc + 1'b1)) == '0
    ) else $error("Command queue lanes accepted out of order: %b", $sampled(acc));

endmodule

/* logic/rvv_lite_pkg.sv */
package rvv_lite_pkg;

    // Command queue push lanes and depth
    localparam int issue_lanes = 2;
    localparam int cq_depth    = 8;

    // Reorder buffer
    localparam int rob_depth = 8;
    localparam int rob_idx_w = 3;

    // Vector shape of four 8-bit elements
    localparam int vlen     = 32;
    localparam int sew      = 8;
    localparam int num_elem = 4;

    localparam int mul_stages = 3;

    // Width of the issuer tag that comes back at retire
    localparam int tag_w = 8;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } op_e;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        op_e              op;
        logic [vlen-1:0]  src_a;
        logic [vlen-1:0]  src_b;
    } cmd_t;

    typedef struct packed {
        logic [rob_idx_w-1:0] rob_idx;
        op_e                  op;
        logic [vlen-1:0]      src_a;
        logic [vlen-1:0]      src_b;
    } issue_t;

    typedef struct packed {
        logic [rob_idx_w-1:0] rob_idx;
        logic [vlen-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [vlen-1:0]  data;
    } retire_t;

endpackage
